// ==== verilog/trig_proc_pkg.sv ====
`default_nettype none

package trig_proc_pkg;

    // system sizes
    localparam int NSURF   = 4;
    localparam int NBIT    = 16;
    localparam int ADDR_W  = 12;
    localparam int TIME_W  = 32;
    localparam int EVNUM_W = 12;
    localparam int QDEPTH  = 8;
    localparam int QPTR_W  = $clog2(QDEPTH);
    localparam int LAT_W   = 16;

    // trigger type, bits 15:14 of a surface word
    typedef enum logic [1:0] {
        OP_IDLE = 2'd0,
        OP_RF   = 2'd1,
        OP_SOFT = 2'd2,
        OP_CAL  = 2'd3
    } trig_op_e;

    // one surface word as it arrives on the link
    typedef struct packed {
        trig_op_e          op;
        logic [1:0]        rsvd;
        logic [ADDR_W-1:0] addr;
    } trig_word_t;

    // decoded candidate out of the decode stage
    typedef struct packed {
        logic              valid;
        trig_op_e          op;
        logic [NSURF-1:0]  surf_hits;
        logic [ADDR_W-1:0] addr;
        logic              ext;
    } trig_cand_t;

    // accepted event, stamped and numbered
    typedef struct packed {
        trig_op_e           op;
        logic [NSURF-1:0]   surf_hits;
        logic [ADDR_W-1:0]  addr;
        logic               ext;
        logic [EVNUM_W-1:0] evnum;
        logic [TIME_W-1:0]  stamp;
    } trig_event_t;

    // 64-bit event header, msb first
    typedef struct packed {
        logic [TIME_W-1:0]  stamp;
        logic [EVNUM_W-1:0] evnum;
        trig_op_e           op;
        logic               ext;
        logic               spare;
        logic [NSURF-1:0]   surf_hits;
        logic [ADDR_W-1:0]  addr;
    } trig_hdr_t;

endpackage

`default_nettype wire

// ==== verilog/trig_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module trig_decode (
    input  wire                                                     sys_clk,
    input  wire                                                     runrst,
    input  wire [trig_proc_pkg::NSURF*trig_proc_pkg::NBIT-1:0]      trigin_dat_i,
    input  wire                                                     trigin_valid_i,
    input  wire [trig_proc_pkg::NSURF-1:0]                          trigmask_i,
    input  wire                                                     trigmask_update_i,
    input  wire [trig_proc_pkg::ADDR_W-1:0]                         ext_trig_i,
    input  wire                                                     ext_valid_i,
    input  wire                                                     runstop_i,
    output trig_proc_pkg::trig_cand_t                               cand_o
);

    logic [trig_proc_pkg::NSURF-1:0]  mask_q;
    trig_proc_pkg::trig_word_t        words [trig_proc_pkg::NSURF];
    logic [trig_proc_pkg::NSURF-1:0]  hits;
    trig_proc_pkg::trig_op_e          pick_op;
    logic [trig_proc_pkg::ADDR_W-1:0] pick_addr;
    trig_proc_pkg::trig_cand_t        cand_d;

    // run-time surface mask, all surfaces enabled out of reset
    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            mask_q <= '1;
        end else if (trigmask_update_i) begin
            mask_q <= trigmask_i;
        end
    end

    // split words and score hits, only while the strobe is up
    always_comb begin
        for (int s = 0; s < trig_proc_pkg::NSURF; s++) begin
            words[s] = trigin_dat_i[s*trig_proc_pkg::NBIT +: trig_proc_pkg::NBIT];
            hits[s]  = trigin_valid_i && mask_q[s] &&
                       (words[s].op != trig_proc_pkg::OP_IDLE);
        end
    end

    // priority scan, walking down so the lowest hit surface wins
    always_comb begin
        pick_op   = trig_proc_pkg::OP_IDLE;
        pick_addr = '0;
        for (int s = trig_proc_pkg::NSURF - 1; s >= 0; s--) begin
            if (hits[s]) begin
                pick_op   = words[s].op;
                pick_addr = words[s].addr;
            end
        end
    end

    // external trigger overrides type and address
    always_comb begin
        cand_d.surf_hits = hits;
        cand_d.ext       = ext_valid_i;
        cand_d.op        = ext_valid_i ? trig_proc_pkg::OP_CAL : pick_op;
        cand_d.addr      = ext_valid_i ? ext_trig_i : pick_addr;
        cand_d.valid     = ((|hits) || ext_valid_i) && !runstop_i;
    end

    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            cand_o <= '0;
        end else begin
            cand_o <= cand_d;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/trig_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module trig_execute (
    input  wire                                 sys_clk,
    input  wire                                 runrst,
    input  wire trig_proc_pkg::trig_cand_t      cand_i,
    input  wire [trig_proc_pkg::LAT_W-1:0]      trig_latency_i,
    output trig_proc_pkg::trig_event_t          event_o,
    output logic                                release_o,
    output logic                                overflow_o
);

    logic [trig_proc_pkg::TIME_W-1:0]  run_timer;
    logic [trig_proc_pkg::EVNUM_W-1:0] evnum_q;

    // hold queue storage, event payload plus its release time
    trig_proc_pkg::trig_event_t        q_evt [trig_proc_pkg::QDEPTH];
    logic [trig_proc_pkg::TIME_W-1:0]  q_rel [trig_proc_pkg::QDEPTH];
    logic [trig_proc_pkg::QPTR_W-1:0]  wr_ptr;
    logic [trig_proc_pkg::QPTR_W-1:0]  rd_ptr;
    logic [trig_proc_pkg::QPTR_W:0]    q_count;

    logic                              q_full;
    logic                              accept;
    logic                              pop;
    logic [trig_proc_pkg::TIME_W-1:0]  head_diff;
    trig_proc_pkg::trig_event_t        new_evt;
    logic [trig_proc_pkg::TIME_W-1:0]  new_rel;

    // free-running run clock, only runrst brings it back to zero
    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            run_timer <= '0;
        end else begin
            run_timer <= run_timer + 1'b1;
        end
    end

    assign q_full = (q_count == (trig_proc_pkg::QPTR_W + 1)'(trig_proc_pkg::QDEPTH));
    assign accept = cand_i.valid && !q_full;

    // head is due once the timer reaches its release time
    // difference test keeps this correct across timer wrap
    assign head_diff = run_timer - q_rel[rd_ptr];
    assign pop       = (q_count != '0) && !head_diff[trig_proc_pkg::TIME_W-1];

    always_comb begin
        new_evt.op        = cand_i.op;
        new_evt.surf_hits = cand_i.surf_hits;
        new_evt.addr      = cand_i.addr;
        new_evt.ext       = cand_i.ext;
        new_evt.evnum     = evnum_q;
        new_evt.stamp     = run_timer;
        new_rel           = run_timer + trig_proc_pkg::TIME_W'(trig_latency_i);
    end

    // queue write side, latency is frozen into the entry here
    always_ff @(posedge sys_clk) begin
        if (accept) begin
            q_evt[wr_ptr] <= new_evt;
            q_rel[wr_ptr] <= new_rel;
        end
    end

    // pointers wrap on their own since QDEPTH is a power of two
    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({accept, pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
        end
    end

    // event numbers are only spent on accepted events
    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            evnum_q <= '0;
        end else if (accept) begin
            evnum_q <= evnum_q + 1'b1;
        end
    end

    // sticky drop flag
    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            overflow_o <= 1'b0;
        end else if (cand_i.valid && q_full) begin
            overflow_o <= 1'b1;
        end
    end

    // registered release, one event per cycle at most
    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            release_o <= 1'b0;
        end else begin
            release_o <= pop;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (pop) begin
            event_o <= q_evt[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/trig_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module trig_result (
    input  wire                                 sys_clk,
    input  wire                                 runrst,
    input  wire trig_proc_pkg::trig_event_t     event_i,
    input  wire                                 release_i,
    output trig_proc_pkg::trig_hdr_t            hdr_o,
    output logic                                hdr_valid_o
);

    trig_proc_pkg::trig_hdr_t hdr_d;

    // map event fields onto the header layout
    always_comb begin
        hdr_d.stamp     = event_i.stamp;
        hdr_d.evnum     = event_i.evnum;
        hdr_d.op        = event_i.op;
        hdr_d.ext       = event_i.ext;
        hdr_d.spare     = 1'b0;
        hdr_d.surf_hits = event_i.surf_hits;
        hdr_d.addr      = event_i.addr;
    end

    // header holds its last value between pulses
    always_ff @(posedge sys_clk) begin
        if (release_i) begin
            hdr_o <= hdr_d;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            hdr_valid_o <= 1'b0;
        end else begin
            hdr_valid_o <= release_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/trig_process_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module trig_process_top (
    input  wire                                                     sys_clk,
    input  wire                                                     runrst,
    input  wire [trig_proc_pkg::NSURF*trig_proc_pkg::NBIT-1:0]      trigin_dat_i,
    input  wire                                                     trigin_valid_i,
    input  wire [trig_proc_pkg::NSURF-1:0]                          trigmask_i,
    input  wire                                                     trigmask_update_i,
    input  wire [trig_proc_pkg::LAT_W-1:0]                          trig_latency_i,
    input  wire [trig_proc_pkg::ADDR_W-1:0]                         ext_trig_i,
    input  wire                                                     ext_valid_i,
    input  wire                                                     runstop_i,
    output trig_proc_pkg::trig_hdr_t                                hdr_o,
    output logic                                                    hdr_valid_o,
    output logic                                                    overflow_o
);

    trig_proc_pkg::trig_cand_t  cand;
    trig_proc_pkg::trig_event_t evt;
    logic                       evt_release;

    // surface words and external trigger into one candidate
    trig_decode i_decode (
        .sys_clk           (sys_clk),
        .runrst            (runrst),
        .trigin_dat_i      (trigin_dat_i),
        .trigin_valid_i    (trigin_valid_i),
        .trigmask_i        (trigmask_i),
        .trigmask_update_i (trigmask_update_i),
        .ext_trig_i        (ext_trig_i),
        .ext_valid_i       (ext_valid_i),
        .runstop_i         (runstop_i),
        .cand_o            (cand)
    );

    // stamping, numbering and latency hold
    trig_execute i_execute (
        .sys_clk        (sys_clk),
        .runrst         (runrst),
        .cand_i         (cand),
        .trig_latency_i (trig_latency_i),
        .event_o        (evt),
        .release_o      (evt_release),
        .overflow_o     (overflow_o)
    );

    trig_result i_result (
        .sys_clk     (sys_clk),
        .runrst      (runrst),
        .event_i     (evt),
        .release_i   (evt_release),
        .hdr_o       (hdr_o),
        .hdr_valid_o (hdr_valid_o)
    );

endmodule

`default_nettype wire

// ==== test/trig_process_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module trig_process_assert (
    input wire                                 sys_clk,
    input wire                                 runrst,
    input wire trig_proc_pkg::trig_hdr_t       hdr_o,
    input wire                                 hdr_valid_o,
    input wire                                 overflow_o,
    input wire [trig_proc_pkg::LAT_W-1:0]      trig_latency_i,
    input wire [trig_proc_pkg::QPTR_W:0]       q_count
);

    logic [trig_proc_pkg::EVNUM_W-1:0] last_evnum;
    logic                              have_last;

    // event number of the previous header pulse
    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            have_last  <= 1'b0;
            last_evnum <= '0;
        end else if (hdr_valid_o) begin
            have_last  <= 1'b1;
            last_evnum <= hdr_o.evnum;
        end
    end

    reset_clear: assert property (@(posedge sys_clk)
        $fell(runrst) |-> (!hdr_valid_o && !overflow_o))
        else $error("header valid or overflow set right after reset");

    evnum_step: assert property (@(posedge sys_clk) disable iff (runrst)
        (hdr_valid_o && have_last) |-> (hdr_o.evnum == trig_proc_pkg::EVNUM_W'(last_evnum + 1'b1)))
        else $error("event number did not step by one");

    // the last queued event leaves a single pulse
    single_pulse: assert property (@(posedge sys_clk) disable iff (runrst)
        (hdr_valid_o && $past(q_count) == '0 && $stable(trig_latency_i)) |=> !hdr_valid_o)
        else $error("header valid held for two cycles");

endmodule

bind trig_process_top trig_process_assert i_assert (
    .sys_clk        (sys_clk),
    .runrst         (runrst),
    .hdr_o          (hdr_o),
    .hdr_valid_o    (hdr_valid_o),
    .overflow_o     (overflow_o),
    .trig_latency_i (trig_latency_i),
    .q_count        (i_execute.q_count)
);

`default_nettype wire

// ==== test/tb_trig_process.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_trig_process;

    localparam int NS     = trig_proc_pkg::NSURF;
    localparam int NB     = trig_proc_pkg::NBIT;
    localparam int MAXVEC = 64;

    logic                              sys_clk;
    logic                              runrst;
    logic [NS*NB-1:0]                  trigin_dat_i;
    logic                              trigin_valid_i;
    logic [NS-1:0]                     trigmask_i;
    logic                              trigmask_update_i;
    logic [trig_proc_pkg::LAT_W-1:0]   trig_latency_i;
    logic [trig_proc_pkg::ADDR_W-1:0]  ext_trig_i;
    logic                              ext_valid_i;
    logic                              runstop_i;
    trig_proc_pkg::trig_hdr_t          hdr_o;
    logic                              hdr_valid_o;
    logic                              overflow_o;

    // stimulus table as read from the vector file
    int                                gap_v [MAXVEC];
    logic [NS*NB-1:0]                  dat_v [MAXVEC];
    logic                              str_v [MAXVEC];
    logic [trig_proc_pkg::ADDR_W-1:0]  ea_v [MAXVEC];
    logic                              ev_v [MAXVEC];
    logic [NS-1:0]                     mk_v [MAXVEC];
    logic                              up_v [MAXVEC];
    logic                              rs_v [MAXVEC];
    int                                nvec = 0;
    int                                lat = 0;
    int                                gap_sum = 0;

    // reference model state
    int                                cyc = 0;
    logic [trig_proc_pkg::TIME_W-1:0]  tb_timer = '0;
    logic [trig_proc_pkg::EVNUM_W-1:0] exp_evnum;
    logic [NS-1:0]                     mask_m;
    logic                              exp_ovf;
    int                                acc_cyc [$];
    trig_proc_pkg::trig_hdr_t          exp_hdr [$];
    int                                exp_due [$];
    string                             exp_name [$];

    int                                err_val = 0;
    int                                err_proto = 0;
    int                                limit = 0;
    integer                            seed = 32'h1f365f96;

    // file parsing scratch
    integer                            fd;
    integer                            code;
    string                             line;
    int                                g;
    int                                st;
    int                                ev;
    int                                up;
    int                                rs;
    logic [NB-1:0]                     w0;
    logic [NB-1:0]                     w1;
    logic [NB-1:0]                     w2;
    logic [NB-1:0]                     w3;
    logic [trig_proc_pkg::ADDR_W-1:0]  ea;
    logic [NS-1:0]                     mk;
    bit                                got_lat;

    trig_process_top i_dut (
        .sys_clk           (sys_clk),
        .runrst            (runrst),
        .trigin_dat_i      (trigin_dat_i),
        .trigin_valid_i    (trigin_valid_i),
        .trigmask_i        (trigmask_i),
        .trigmask_update_i (trigmask_update_i),
        .trig_latency_i    (trig_latency_i),
        .ext_trig_i        (ext_trig_i),
        .ext_valid_i       (ext_valid_i),
        .runstop_i         (runstop_i),
        .hdr_o             (hdr_o),
        .hdr_valid_o       (hdr_valid_o),
        .overflow_o        (overflow_o)
    );

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    // cycle count and a copy of the run timer
    always @(posedge sys_clk) begin
        cyc <= cyc + 1;
        if (runrst) begin
            tb_timer <= '0;
        end else begin
            tb_timer <= tb_timer + 32'd1;
        end
    end

    always @(posedge sys_clk) begin
        if (limit > 0 && cyc >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // header check, sampled away from the rising edge
    always @(negedge sys_clk) begin
        if (exp_due.size() > 0 && exp_due[0] == cyc) begin
            assert (hdr_valid_o) else begin
                $display("no header pulse for %s at cycle %0d", exp_name[0], cyc);
                err_proto++;
            end
            if (hdr_valid_o) begin
                assert (hdr_o == exp_hdr[0]) else begin
                    $display("Error %s: expected %h, actual %h", exp_name[0], exp_hdr[0], hdr_o);
                    err_val++;
                end
            end
            void'(exp_due.pop_front());
            void'(exp_hdr.pop_front());
            void'(exp_name.pop_front());
        end else begin
            assert (!hdr_valid_o) else begin
                $display("header pulse at cycle %0d with none expected", cyc);
                err_proto++;
            end
        end
    end

    task automatic drive_idle();
        trigin_dat_i      = '0;
        trigin_valid_i    = 1'b0;
        trigmask_update_i = 1'b0;
        ext_trig_i        = '0;
        ext_valid_i       = 1'b0;
        runstop_i         = 1'b0;
    endtask

    task automatic reset_model();
        exp_evnum = '0;
        mask_m    = '1;
        exp_ovf   = 1'b0;
        acc_cyc.delete();
    endtask

    // apply one vector and predict its header from the decode rules
    task automatic drive_vector(input int idx, input string name);
        logic [NS*NB-1:0]         dat;
        logic [NS-1:0]            hits;
        trig_proc_pkg::trig_hdr_t hdr;
        bit                       valid;
        int                       first;
        dat   = dat_v[idx];
        hdr   = '0;
        first = -1;
        for (int s = 0; s < NS; s++) begin
            if (dat[s*NB+14 +: 2] == 2'b00) begin
                dat[s*NB +: 12] = 12'($random(seed));
            end
            hits[s] = str_v[idx] && mask_m[s] && (dat[s*NB+14 +: 2] != 2'b00);
            if (hits[s] && first < 0) begin
                first = s;
            end
        end
        if (first >= 0) begin
            hdr.op   = trig_proc_pkg::trig_op_e'(dat[first*NB+14 +: 2]);
            hdr.addr = dat[first*NB +: 12];
        end
        if (ev_v[idx]) begin
            hdr.ext  = 1'b1;
            hdr.op   = trig_proc_pkg::OP_CAL;
            hdr.addr = ea_v[idx];
        end
        hdr.surf_hits = hits;
        valid = ((hits != '0) || ev_v[idx]) && !rs_v[idx];
        if (valid) begin
            // entries still held when this candidate reaches the queue
            while (acc_cyc.size() > 0 && acc_cyc[0] + lat < cyc) begin
                void'(acc_cyc.pop_front());
            end
            if (acc_cyc.size() >= trig_proc_pkg::QDEPTH) begin
                exp_ovf = 1'b1;
            end else begin
                hdr.evnum = exp_evnum;
                hdr.stamp = tb_timer + 32'd1;
                exp_evnum = exp_evnum + 1'b1;
                acc_cyc.push_back(cyc);
                exp_hdr.push_back(hdr);
                exp_due.push_back(cyc + lat + 3);
                exp_name.push_back(name);
            end
        end
        if (up_v[idx]) begin
            mask_m = mk_v[idx];
        end
        trigin_dat_i      = dat;
        trigin_valid_i    = str_v[idx];
        ext_trig_i        = ea_v[idx];
        ext_valid_i       = ev_v[idx];
        trigmask_i        = mk_v[idx];
        trigmask_update_i = up_v[idx];
        runstop_i         = rs_v[idx];
    endtask

    task automatic play_vector(input int idx, input string name);
        for (int k = 1; k < gap_v[idx]; k++) begin
            @(negedge sys_clk);
            drive_idle();
        end
        @(negedge sys_clk);
        drive_vector(idx, name);
    endtask

    task automatic wait_drain();
        while (exp_due.size() > 0) begin
            @(negedge sys_clk);
        end
        repeat (3) @(negedge sys_clk);
    endtask

    initial begin
        runrst         = 1'b1;
        trigmask_i     = '1;
        trig_latency_i = '0;
        drive_idle();
        reset_model();
        got_lat = 1'b0;
        fd = $fopen("test/trig_process_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            while (!$feof(fd) && nvec < MAXVEC) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line[0] != "#") begin
                    if (!got_lat) begin
                        code    = $sscanf(line, "%d", lat);
                        got_lat = 1'b1;
                    end else begin
                        code = $sscanf(line, "%d %h %h %h %h %d %h %d %h %d %d",
                                       g, w0, w1, w2, w3, st, ea, ev, mk, up, rs);
                        if (code == 11) begin
                            gap_v[nvec] = g;
                            dat_v[nvec] = {w3, w2, w1, w0};
                            str_v[nvec] = st[0];
                            ea_v[nvec]  = ea;
                            ev_v[nvec]  = ev[0];
                            mk_v[nvec]  = mk;
                            up_v[nvec]  = up[0];
                            rs_v[nvec]  = rs[0];
                            gap_sum     = gap_sum + g;
                            nvec++;
                        end else begin
                            $display("vector line could not be parsed: %s", line);
                            err_proto++;
                        end
                    end
                end
            end
            $fclose(fd);
            trig_latency_i = trig_proc_pkg::LAT_W'(lat);
            // file playback plus the replay after the run reset
            limit = gap_sum + lat + 50 + 4 + gap_v[0] + lat + 10;
            repeat (4) @(negedge sys_clk);
            runrst = 1'b0;
            for (int i = 0; i < nvec; i++) begin
                play_vector(i, $sformatf("vector_%0d", i));
            end
            @(negedge sys_clk);
            drive_idle();
            wait_drain();
            assert (overflow_o == exp_ovf) else begin
                $display("Error overflow: expected %0b, actual %0b", exp_ovf, overflow_o);
                err_val++;
            end
            // run reset, then the first vector again from a cleared timer
            runrst = 1'b1;
            reset_model();
            repeat (4) @(negedge sys_clk);
            runrst = 1'b0;
            play_vector(0, "reset_replay");
            @(negedge sys_clk);
            drive_idle();
            wait_drain();
            assert (overflow_o == 1'b0) else begin
                $display("Error overflow_after_reset: expected 0, actual %0b", overflow_o);
                err_val++;
            end
            $display("value errors: %0d, protocol errors: %0d", err_val, err_proto);
            if (err_val + err_proto == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== test/trig_process_vectors.txt ====
# first data line is the latency (decimal), then one line per driven cycle
# gap(dec) w0 w1 w2 w3 strobe ext_addr ext_valid mask mask_update runstop
20
3  0000 4123 0000 0000 1 000 0 f 0 0
30 0000 0000 0000 0000 0 000 0 d 1 0
2  0000 8456 0000 0000 1 000 0 d 0 0
2  0000 8111 4222 0000 1 000 0 d 0 0
30 c333 4444 8555 c666 1 000 0 d 0 0
3  4777 0000 8888 0000 1 9ab 1 d 0 0
3  0000 0000 0000 0000 0 0cd 1 d 0 0
30 0000 0000 0000 0000 0 000 0 f 1 0
3  4101 0000 0000 0000 1 000 0 f 0 0
1  0000 8202 0000 0000 1 000 0 f 0 0
1  0000 0000 c303 0000 1 000 0 f 0 0
1  0000 0000 0000 4404 1 000 0 f 0 0
1  8505 4515 0000 0000 1 000 0 f 0 0
30 4a00 0000 0000 0000 1 000 0 f 0 0
1  4a01 0000 0000 0000 1 000 0 f 0 0
1  0000 8a02 0000 0000 1 000 0 f 0 0
1  0000 0000 ca03 0000 1 000 0 f 0 0
1  0000 0000 0000 4a04 1 000 0 f 0 0
1  8a05 0000 0000 0000 1 000 0 f 0 0
1  0000 4a06 0000 0000 1 000 0 f 0 0
1  0000 0000 8a07 0000 1 000 0 f 0 0
1  0000 0000 0000 ca08 1 000 0 f 0 0
1  4a09 0000 0000 0000 1 000 0 f 0 0
40 4bbb 0000 0000 0000 1 000 0 f 0 1
2  0000 0000 8ccc 0000 1 000 0 f 0 0

// ==== trig_process.f ====
verilog/trig_proc_pkg.sv
verilog/trig_decode.sv
verilog/trig_execute.sv
verilog/trig_result.sv
verilog/trig_process_top.sv
test/trig_process_assert.sv
test/tb_trig_process.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the trigger processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f trig_process.f \
    --top-module tb_trig_process -Mdir obj_dir -o tb_trig_process > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/tb_trig_process > "$LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status, see $LOG"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see $LOG"
exit 1
